// ==== hdl/char_cfg.svh ====
// Tilemap, tile, line geometry and credit depth defines for the character layer
`ifndef CHAR_CFG_SVH
`define CHAR_CFG_SVH

// Tilemap of 64 columns by 32 rows
`define CHAR_MAP_AW 11

// Tile code field of a tilemap word
`define CHAR_CODE_W 9

// Last tilemap row holds the row scroll words
`define CHAR_SCROLL_ROW 31

// 32 visible tiles plus one for the fine scroll
`define CHAR_LINE_TILES 33
`define CHAR_LINE_PIXELS 256

// Credits per link
`define CHAR_STAGE_CREDITS 4
`define CHAR_MEM_CREDITS 4
`define CHAR_PIXEL_CREDITS 8

`endif

// ==== hdl/char_pkg.sv ====
// Package with the CPU bus, tile entry, graphics request, row and pixel structs
`include "char_cfg.svh"

package char_pkg;

    // CPU access to the tilemap
    // Byte enables active low, bit 0 is the low byte
    typedef struct packed {
        logic                    sel;
        logic [`CHAR_MAP_AW-1:0] addr;
        logic [15:0]             wdata;
        logic [1:0]              dsn;
    } cpu_bus_t;

    // Scan stage output
    typedef struct packed {
        logic [`CHAR_CODE_W-1:0] code;
        logic [2:0]              pal;
        logic                    prio;
        logic [2:0]              vline;
        logic                    first;
    } tile_entry_t;

    // Row address in graphics memory
    typedef struct packed {
        logic [`CHAR_CODE_W-1:0] code;
        logic [2:0]              vline;
        logic                    lsb;
    } gfx_req_t;

    // One tile row, leftmost pixel in each MSB
    typedef struct packed {
        logic [7:0] plane2;
        logic [7:0] plane1;
        logic [7:0] plane0;
    } gfx_rsp_t;

    // Row rejoined with its tile attributes
    typedef struct packed {
        gfx_rsp_t   planes;
        logic [2:0] pal;
        logic       prio;
        logic       first;
    } gfx_row_t;

    // Colour is priority, palette, then planes 2 to 0
    typedef struct packed {
        logic [7:0] x;
        logic [6:0] colour;
        logic       last;
    } pixel_t;

endpackage

// ==== hdl/tile_ram.sv ====
// Dual-port tilemap RAM with CPU byte-lane writes and a read-only scan port
`include "char_cfg.svh"

module tile_ram (
    input  logic                    clk,
    input  char_pkg::cpu_bus_t      cpu,
    output logic [15:0]             cpu_din,
    input  logic [`CHAR_MAP_AW-1:0] scan_addr,
    output logic [15:0]             scan_q
);

    logic [15:0] mem [0:(1 << `CHAR_MAP_AW)-1];
    logic [1:0]  we;

    // One enable per byte lane
    assign we = ~cpu.dsn & {2{cpu.sel}};

    // CPU port
    // Read data is the word before this cycle's write
    always_ff @(posedge clk) begin
        if (we[0]) begin
            mem[cpu.addr][7:0] <= cpu.wdata[7:0];
        end
        if (we[1]) begin
            mem[cpu.addr][15:8] <= cpu.wdata[15:8];
        end
        cpu_din <= mem[cpu.addr];
    end

    // Scan port, reads only
    always_ff @(posedge clk) begin
        scan_q <= mem[scan_addr];
    end

endmodule

// ==== hdl/credit_fifo.sv ====
// Credit link receive buffer for any payload type, one credit back per pop
`include "char_cfg.svh"

module credit_fifo #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     credit,
    output payload_t out_data,
    output logic     out_ready,
    input  logic     pop
);

    localparam int DEPTH = `CHAR_STAGE_CREDITS;
    localparam int PW    = $clog2(DEPTH);
    localparam int CW    = $clog2(DEPTH + 1);

    payload_t      slots [0:DEPTH-1];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_pop;

    // Pop of an empty buffer does nothing
    assign do_pop    = pop && out_ready;
    assign out_ready = count != '0;
    assign out_data  = slots[rd_ptr];

    always_ff @(posedge clk) begin
        if (in_valid) begin
            slots[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (in_valid) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count  <= count + CW'(in_valid) - CW'(do_pop);
            // Freed slot goes back to the sender
            credit <= do_pop;
        end
    end

endmodule

// ==== hdl/tile_scan.sv ====
// Stage 1 scans the row scroll word and the tile entries of each line
`include "char_cfg.svh"

module tile_scan (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    line_start,
    input  logic [7:0]              line,
    output logic [`CHAR_MAP_AW-1:0] scan_addr,
    input  logic [15:0]             scan_q,
    output char_pkg::tile_entry_t   entry,
    output logic                    entry_valid,
    input  logic                    entry_credit,
    output logic [2:0]              fine_scroll,
    input  logic                    line_done,
    output logic                    line_busy
);

    localparam int CW = $clog2(`CHAR_STAGE_CREDITS + 1);

    typedef enum logic [1:0] {
        IDLE,
        SCROLL_RD,
        SCROLL_CAP,
        WALK
    } state_t;

    state_t        state;
    logic [4:0]    tile_row;
    logic [2:0]    vline;
    logic [5:0]    col;
    logic [5:0]    tile_cnt;
    logic [CW-1:0] credits;
    logic          rd;
    logic          rd_pend;
    logic          first_pend;

    // One tile read per cycle while credits remain
    assign rd = (state == WALK) && (credits != '0);

    // Scroll word of tile row r sits at column 2r of the scroll row
    always_comb begin
        if (state == SCROLL_RD) begin
            scan_addr = {5'(`CHAR_SCROLL_ROW), tile_row, 1'b0};
        end else begin
            scan_addr = {tile_row, col};
        end
    end

    // Entry leaves with the RAM data, one cycle after its read
    assign entry_valid = rd_pend;

    always_comb begin
        entry.code  = scan_q[`CHAR_CODE_W-1:0];
        entry.pal   = scan_q[11:9];
        entry.prio  = scan_q[12];
        entry.vline = vline;
        entry.first = first_pend;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= IDLE;
            tile_row    <= '0;
            vline       <= '0;
            col         <= '0;
            tile_cnt    <= '0;
            fine_scroll <= '0;
            credits     <= CW'(`CHAR_STAGE_CREDITS);
            rd_pend     <= 1'b0;
            first_pend  <= 1'b0;
            line_busy   <= 1'b0;
        end else begin
            rd_pend    <= rd;
            first_pend <= rd && (tile_cnt == '0);
            credits    <= credits - CW'(rd) + CW'(entry_credit);

            case (state)
                IDLE: begin
                    if (line_start) begin
                        tile_row <= line[7:3];
                        vline    <= line[2:0];
                        state    <= SCROLL_RD;
                    end
                end
                SCROLL_RD: begin
                    state <= SCROLL_CAP;
                end
                SCROLL_CAP: begin
                    // Coarse part picks the first column, fine part goes downstream
                    col         <= scan_q[8:3];
                    fine_scroll <= scan_q[2:0];
                    tile_cnt    <= '0;
                    state       <= WALK;
                end
                default: begin
                    // Column wraps at 64 by width
                    if (rd) begin
                        col      <= col + 6'd1;
                        tile_cnt <= tile_cnt + 6'd1;
                        if (tile_cnt == 6'(`CHAR_LINE_TILES - 1)) begin
                            state <= IDLE;
                        end
                    end
                end
            endcase

            // Busy until the last pixel has left
            if (line_start) begin
                line_busy <= 1'b1;
            end else if (line_done) begin
                line_busy <= 1'b0;
            end
        end
    end

endmodule

// ==== hdl/gfx_fetch.sv ====
// Stage 2 issues graphics requests and rejoins the responses with tile attributes
`include "char_cfg.svh"

module gfx_fetch (
    input  logic                  clk,
    input  logic                  rst,
    input  char_pkg::tile_entry_t entry,
    input  logic                  entry_valid,
    output logic                  entry_credit,
    output char_pkg::gfx_req_t    req,
    output logic                  req_valid,
    input  logic                  req_credit,
    input  char_pkg::gfx_rsp_t    rsp,
    input  logic                  rsp_valid,
    output char_pkg::gfx_row_t    row,
    output logic                  row_valid,
    input  logic                  row_credit
);

    localparam int MCW = $clog2(`CHAR_MEM_CREDITS + 1);
    localparam int RCW = $clog2(`CHAR_STAGE_CREDITS + 1);
    localparam int TQ  = `CHAR_MEM_CREDITS;
    localparam int TPW = $clog2(TQ);

    // Attributes waiting for their graphics data
    typedef struct packed {
        logic [2:0] pal;
        logic       prio;
        logic       first;
    } tag_t;

    char_pkg::tile_entry_t head;
    logic                  head_ready;
    logic                  issue;
    logic [MCW-1:0]        mem_cred;
    logic [RCW-1:0]        row_cred;
    tag_t                  tags [0:TQ-1];
    logic [TPW-1:0]        tag_wr;
    logic [TPW-1:0]        tag_rd;
    tag_t                  tag_head;

    credit_fifo #(
        .payload_t (char_pkg::tile_entry_t)
    ) i_entry_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (entry_valid),
        .in_data   (entry),
        .credit    (entry_credit),
        .out_data  (head),
        .out_ready (head_ready),
        .pop       (issue)
    );

    // Row credit reserved at issue
    // so every response has a downstream slot waiting
    assign issue    = head_ready && (mem_cred != '0) && (row_cred != '0);
    assign tag_head = tags[tag_rd];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_valid <= 1'b0;
            row_valid <= 1'b0;
            mem_cred  <= MCW'(`CHAR_MEM_CREDITS);
            row_cred  <= RCW'(`CHAR_STAGE_CREDITS);
            tag_wr    <= '0;
            tag_rd    <= '0;
        end else begin
            req_valid <= issue;
            row_valid <= rsp_valid;
            mem_cred  <= mem_cred - MCW'(issue) + MCW'(req_credit);
            row_cred  <= row_cred - RCW'(issue) + RCW'(row_credit);
            // Responses return in request order
            if (issue) begin
                tag_wr <= tag_wr + 1'b1;
            end
            if (rsp_valid) begin
                tag_rd <= tag_rd + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            req.code      <= head.code;
            req.vline     <= head.vline;
            req.lsb       <= 1'b0;
            tags[tag_wr]  <= '{head.pal, head.prio, head.first};
        end
        if (rsp_valid) begin
            row.planes <= rsp;
            row.pal    <= tag_head.pal;
            row.prio   <= tag_head.prio;
            row.first  <= tag_head.first;
        end
    end

endmodule

// ==== hdl/pixel_shift.sv ====
// Stage 3 shifts plane bits into pixels, drops the fine scroll and counts x
`include "char_cfg.svh"

module pixel_shift (
    input  logic               clk,
    input  logic               rst,
    input  char_pkg::gfx_row_t row,
    input  logic               row_valid,
    output logic               row_credit,
    input  logic [2:0]         fine_scroll,
    output char_pkg::pixel_t   px,
    output logic               px_valid,
    input  logic               px_credit,
    output logic               line_done
);

    localparam int PCW = $clog2(`CHAR_PIXEL_CREDITS + 1);

    char_pkg::gfx_row_t head;
    logic               head_ready;
    logic               pop;
    logic               load;
    logic               discard;
    logic               emit;
    logic               last_px;
    logic               need_row;
    logic [2:0]         skip;
    logic [7:0]         p0;
    logic [7:0]         p1;
    logic [7:0]         p2;
    logic [2:0]         pal;
    logic               prio;
    logic [3:0]         bits_left;
    logic [7:0]         x_cnt;
    logic [PCW-1:0]     px_cred;
    logic               drop;

    credit_fifo #(
        .payload_t (char_pkg::gfx_row_t)
    ) i_row_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (row_valid),
        .in_data   (row),
        .credit    (row_credit),
        .out_data  (head),
        .out_ready (head_ready),
        .pop       (pop)
    );

    assign emit     = (bits_left != '0) && (px_cred != '0);
    assign last_px  = emit && (x_cnt == 8'(`CHAR_LINE_PIXELS - 1));
    // Next row loads as the current one runs out
    assign need_row = (bits_left == '0) || ((bits_left == 4'd1) && emit);
    // Rows past x = 255 are thrown away until the next line's first row
    assign discard  = drop && head_ready && !head.first;
    assign load     = need_row && head_ready && !last_px && (!drop || head.first);
    assign pop      = load || discard;
    // Only the first row of a line loses pixels
    assign skip     = head.first ? fine_scroll : 3'd0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            px_valid  <= 1'b0;
            line_done <= 1'b0;
            px_cred   <= PCW'(`CHAR_PIXEL_CREDITS);
            x_cnt     <= '0;
            drop      <= 1'b0;
            bits_left <= '0;
        end else begin
            px_valid  <= emit;
            line_done <= last_px;
            px_cred   <= px_cred - PCW'(emit) + PCW'(px_credit);
            // Wraps to 0 after 256 pixels
            if (emit) begin
                x_cnt <= x_cnt + 8'd1;
            end
            if (last_px) begin
                drop <= 1'b1;
            end else if (load) begin
                drop <= 1'b0;
            end
            if (last_px) begin
                bits_left <= '0;
            end else if (load) begin
                bits_left <= 4'd8 - 4'(skip);
            end else if (emit) begin
                bits_left <= bits_left - 4'd1;
            end
        end
    end

    // Plane shifters and pixel payload
    always_ff @(posedge clk) begin
        if (load) begin
            p0   <= head.planes.plane0 << skip;
            p1   <= head.planes.plane1 << skip;
            p2   <= head.planes.plane2 << skip;
            pal  <= head.pal;
            prio <= head.prio;
        end else if (emit) begin
            p0 <= p0 << 1;
            p1 <= p1 << 1;
            p2 <= p2 << 1;
        end
        if (emit) begin
            px.x      <= x_cnt;
            px.colour <= {prio, pal, p2[7], p1[7], p0[7]};
            px.last   <= x_cnt == 8'(`CHAR_LINE_PIXELS - 1);
        end
    end

endmodule

// ==== hdl/char_layer.sv ====
// Character layer top level with tilemap RAM, scan, fetch and pixel stages
`include "char_cfg.svh"

module char_layer (
    input  logic                 clk,
    input  logic                 rst,
    input  char_pkg::cpu_bus_t   cpu,
    output logic [15:0]          cpu_din,
    input  logic                 line_start,
    input  logic [7:0]           line,
    output logic                 line_busy,
    output char_pkg::gfx_req_t   req,
    output logic                 req_valid,
    input  logic                 req_credit,
    input  char_pkg::gfx_rsp_t   rsp,
    input  logic                 rsp_valid,
    output char_pkg::pixel_t     px,
    output logic                 px_valid,
    input  logic                 px_credit
);

    // Scan read port
    logic [`CHAR_MAP_AW-1:0] scan_addr;
    logic [15:0]             scan_q;

    // Scan to fetch link
    char_pkg::tile_entry_t   entry;
    logic                    entry_valid;
    logic                    entry_credit;

    // Fetch to pixel link
    char_pkg::gfx_row_t      row;
    logic                    row_valid;
    logic                    row_credit;

    // Per line side band
    logic [2:0]              fine_scroll;
    logic                    line_done;

    tile_ram i_ram (
        .clk       (clk),
        .cpu       (cpu),
        .cpu_din   (cpu_din),
        .scan_addr (scan_addr),
        .scan_q    (scan_q)
    );

    tile_scan i_scan (
        .clk          (clk),
        .rst          (rst),
        .line_start   (line_start),
        .line         (line),
        .scan_addr    (scan_addr),
        .scan_q       (scan_q),
        .entry        (entry),
        .entry_valid  (entry_valid),
        .entry_credit (entry_credit),
        .fine_scroll  (fine_scroll),
        .line_done    (line_done),
        .line_busy    (line_busy)
    );

    gfx_fetch i_fetch (
        .clk          (clk),
        .rst          (rst),
        .entry        (entry),
        .entry_valid  (entry_valid),
        .entry_credit (entry_credit),
        .req          (req),
        .req_valid    (req_valid),
        .req_credit   (req_credit),
        .rsp          (rsp),
        .rsp_valid    (rsp_valid),
        .row          (row),
        .row_valid    (row_valid),
        .row_credit   (row_credit)
    );

    pixel_shift i_pixel (
        .clk         (clk),
        .rst         (rst),
        .row         (row),
        .row_valid   (row_valid),
        .row_credit  (row_credit),
        .fine_scroll (fine_scroll),
        .px          (px),
        .px_valid    (px_valid),
        .px_credit   (px_credit),
        .line_done   (line_done)
    );

endmodule

// ==== verification/char_layer_properties.sv ====
// Bound checker with credit, line start and reset release assertions on the char_layer ports
`include "char_cfg.svh"

module char_layer_properties (
    input logic clk,
    input logic rst,
    input logic line_start,
    input logic line_busy,
    input logic req_valid,
    input logic req_credit,
    input logic px_valid,
    input logic px_credit
);

    timeunit 1ns;
    timeprecision 100ps;

    // Credit view from the port side
    int mem_cnt;
    int px_cnt;
    int unsigned fail_count;

    initial fail_count = 0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_cnt <= `CHAR_MEM_CREDITS;
            px_cnt  <= `CHAR_PIXEL_CREDITS;
        end else begin
            mem_cnt <= mem_cnt - int'(req_valid) + int'(req_credit);
            px_cnt  <= px_cnt - int'(px_valid) + int'(px_credit);
        end
    end

    // Graphics memory never gets more requests than it can hold
    req_needs_credit: assert property (@(posedge clk) disable iff (rst)
        req_valid |-> mem_cnt > 0)
        else begin
            fail_count++;
            $error("graphics request sent with no memory credit left");
        end

    // Sink overrun
    px_needs_credit: assert property (@(posedge clk) disable iff (rst)
        px_valid |-> px_cnt > 0)
        else begin
            fail_count++;
            $error("pixel sent with no sink credit left");
        end

    no_start_while_busy: assert property (@(posedge clk) disable iff (rst)
        line_start |-> !line_busy)
        else begin
            fail_count++;
            $error("line start arrived while a line was still busy");
        end

    // First clocked cycle out of reset
    quiet_after_reset: assert property (@(posedge clk)
        $fell(rst) |=> !px_valid && !req_valid && !line_busy)
        else begin
            fail_count++;
            $error("outputs active right after reset release");
        end

endmodule

bind char_layer char_layer_properties i_props (
    .clk        (clk),
    .rst        (rst),
    .line_start (line_start),
    .line_busy  (line_busy),
    .req_valid  (req_valid),
    .req_credit (req_credit),
    .px_valid   (px_valid),
    .px_credit  (px_credit)
);

// ==== verification/char_layer_tb.sv ====
// Testbench with clock, reset, CPU port, graphics memory model, pixel sink and reference model
`include "char_cfg.svh"

module char_layer_tb;

    timeunit 1ns;
    timeprecision 100ps;

    logic                 clk = 1'b0;
    logic                 rst = 1'b1;
    char_pkg::cpu_bus_t   cpu;
    logic [15:0]          cpu_din;
    logic                 line_start;
    logic [7:0]           line;
    logic                 line_busy;
    char_pkg::gfx_req_t   req;
    logic                 req_valid;
    logic                 req_credit;
    char_pkg::gfx_rsp_t   rsp;
    logic                 rsp_valid;
    char_pkg::pixel_t     px;
    logic                 px_valid;
    logic                 px_credit;

    logic [15:0] lfsr = 16'd20479;
    logic [15:0] shadow [0:(1 << `CHAR_MAP_AW)-1];
    int          errors = 0;
    int          timeouts = 0;
    int          checks = 0;
    int          total;
    logic        mem_random = 1'b0;
    logic        sink_random = 1'b0;
    // Memory model queue and sink bookkeeping
    logic [12:0] mq_addr [$];
    int          mq_due [$];
    int          cyc = 0;
    int          last_due = 0;
    int          px_pending = 0;
    logic [15:0] q;

    char_layer i_dut (.*);

    always #10 clk = ~clk;

    // Galois LFSR, one step per bit taken
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) begin
                lfsr = lfsr ^ 16'hB400;
            end
            r = {r[14:0], b};
        end
        return r;
    endfunction

    // Memory rule, plane k is the address low byte xor a constant
    function automatic logic [23:0] gfx_planes(input logic [12:0] ga);
        return {ga[7:0] ^ 8'h96, ga[7:0] ^ 8'hC3, ga[7:0] ^ 8'h5A};
    endfunction

    function automatic logic [6:0] expected_colour(input logic [7:0] ln, input int x);
        logic [15:0] scroll;
        logic [15:0] word;
        logic [8:0]  p;
        logic [12:0] ga;
        logic [23:0] pl;
        int          b;
        scroll = shadow[{5'd31, ln[7:3], 1'b0}];
        // Tilemap row pixel wraps at 512
        p      = 9'(x) + scroll[8:0];
        word   = shadow[{ln[7:3], p[8:3]}];
        ga     = {word[8:0], ln[2:0], 1'b0};
        pl     = gfx_planes(ga);
        b      = 7 - int'(p[2:0]);
        return {word[12], word[11:9], pl[16+b], pl[8+b], pl[b]};
    endfunction

    task automatic check_value(input string name, input int exp, input int act);
        checks++;
        assert (exp == act) else begin
            errors++;
            $display("[FAIL] %s expected %0h actual %0h", name, exp, act);
        end
    endtask

    // One CPU cycle, returns the read data of the cycle after
    task automatic cpu_access(input logic [10:0] a, input logic [15:0] d,
                              input logic [1:0] dsn, output logic [15:0] rd);
        cpu = '{1'b1, a, d, dsn};
        @(negedge clk);
        rd  = cpu_din;
        cpu.sel = 1'b0;
        if (!dsn[0]) begin
            shadow[a][7:0] = d[7:0];
        end
        if (!dsn[1]) begin
            shadow[a][15:8] = d[15:8];
        end
    endtask

    task automatic render_line(input logic [7:0] ln, input string name);
        int got;
        int idle;
        got  = 0;
        idle = 0;
        line_start = 1'b1;
        line       = ln;
        @(negedge clk);
        line_start = 1'b0;
        while (got < `CHAR_LINE_PIXELS && idle < 4000) begin
            if (px_valid) begin
                check_value({name, " x"}, got, int'(px.x));
                check_value({name, " colour"}, int'(expected_colour(ln, got)),
                            int'(px.colour));
                check_value({name, " last"}, int'(got == 255), int'(px.last));
                // Busy still high while the last pixel is on the port
                if (got == `CHAR_LINE_PIXELS - 1) begin
                    check_value({name, " busy at last"}, 1, int'(line_busy));
                end
                got++;
                idle = 0;
            end else begin
                idle++;
            end
            @(negedge clk);
        end
        if (got < `CHAR_LINE_PIXELS) begin
            timeouts++;
            $display("Timeout in %s, only %0d pixels arrived", name, got);
        end else begin
            // Busy drops the cycle after the last pixel
            check_value({name, " busy after last"}, 0, int'(line_busy));
        end
        idle = 0;
        while (line_busy && idle < 100) begin
            idle++;
            @(negedge clk);
        end
        if (line_busy) begin
            timeouts++;
            $display("Timeout in %s, line_busy never fell", name);
        end
        check_value({name, " extra pixel"}, 0, int'(px_valid));
    endtask

    // Graphics memory model and pixel sink
    always @(negedge clk) begin
        int lat;
        int due;
        cyc++;
        if (!rst && req_valid) begin
            lat = mem_random ? 1 + int'(rand_bits(3)) % 6 : 1;
            due = cyc + lat;
            if (due <= last_due) begin
                due = last_due + 1;
            end
            mq_addr.push_back(req);
            mq_due.push_back(due);
            last_due = due;
        end
        if (mq_due.size() > 0 && mq_due[0] <= cyc) begin
            rsp        <= gfx_planes(mq_addr.pop_front());
            void'(mq_due.pop_front());
            rsp_valid  <= 1'b1;
            req_credit <= 1'b1;
        end else begin
            rsp_valid  <= 1'b0;
            req_credit <= 1'b0;
        end
        if (!rst && px_valid) begin
            px_pending++;
        end
        if (px_pending > 0 && (!sink_random || rand_bits(2) != 2'd0)) begin
            px_pending--;
            px_credit <= 1'b1;
        end else begin
            px_credit <= 1'b0;
        end
    end

    initial begin
        cpu        = '0;
        line_start = 1'b0;
        line       = '0;
        req_credit <= 1'b0;
        rsp        <= '0;
        rsp_valid  <= 1'b0;
        px_credit  <= 1'b0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        // CPU readback with byte lanes, old word shows on a write
        cpu_access(11'h123, 16'h1234, 2'b00, q);
        cpu_access(11'h123, 16'hFFAB, 2'b10, q);
        check_value("cpu old word", 16'h1234, int'(q));
        cpu_access(11'h123, 16'hCDFF, 2'b01, q);
        check_value("cpu low lane", 16'h12AB, int'(q));
        cpu_access(11'h123, 16'h0000, 2'b11, q);
        check_value("cpu high lane", 16'hCDAB, int'(q));

        // Random tilemap
        for (int a = 0; a < (1 << `CHAR_MAP_AW); a++) begin
            cpu_access(11'(a), rand_bits(16), 2'b00, q);
        end

        // Zero scroll on every tile row
        for (int r = 0; r < 32; r++) begin
            cpu_access({5'd31, 5'(r), 1'b0}, 16'h0000, 2'b00, q);
        end
        render_line(8'd0, "zero scroll line 0");
        render_line(8'd77, "zero scroll line 77");

        for (int r = 0; r < 32; r++) begin
            cpu_access({5'd31, 5'(r), 1'b0}, rand_bits(16), 2'b00, q);
        end
        render_line(8'd13, "row scroll line 13");
        render_line(8'd250, "row scroll line 250");

        mem_random = 1'b1;
        render_line(8'd100, "memory stall line 100");
        render_line(8'd201, "memory stall line 201");

        sink_random = 1'b1;
        render_line(8'd42, "sink stall line 42");
        render_line(8'd255, "sink stall line 255");

        repeat (10) @(negedge clk);
        total = errors + timeouts + int'(i_dut.i_props.fail_count);
        $display("Checks %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
                 checks, errors, timeouts, i_dut.i_props.fail_count);
        if (total == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+hdl
hdl/char_pkg.sv
hdl/tile_ram.sv
hdl/credit_fifo.sv
hdl/tile_scan.sv
hdl/gfx_fetch.sv
hdl/pixel_shift.sv
hdl/char_layer.sv
verification/char_layer_properties.sv
verification/char_layer_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the character layer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module char_layer_tb \
    -f flist.f \
    -o char_layer_sim
if [ $? -ne 0 ]; then
    echo "FAIL: Verilator compile did not succeed"
    exit 1
fi

./obj_dir/char_layer_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "FAIL: simulation exited with status $status"
    exit 1
fi

if grep -q "^Everything OK$" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL: pass message not found in sim.log"
    exit 1
fi
